// File: logic/rn_pkg.sv
`default_nettype none

package rn_pkg;

    localparam int NUM_ARCH = 32;
    localparam int NUM_PHYS = 64;
    localparam int NUM_FREE = 32;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;
    // occupancy must reach NUM_FREE, so one bit wider than a pointer
    typedef logic [5:0]  fl_cnt_t;

    typedef enum logic [2:0] {
        FU_NONE = 3'd0, FU_ALU = 3'd1, FU_MEM = 3'd2, FU_BRA = 3'd3
    } fu_type_e;

    typedef enum logic [3:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        OPSEL_REG, OPSEL_PC, OPSEL_IMM, OPSEL_ZERO
    } op_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_ctrl_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB = 4'd1, MEM_LH = 4'd2, MEM_LW = 4'd3, MEM_LBU = 4'd4, MEM_LHU = 4'd5,
        MEM_SB = 4'd8, MEM_SH = 4'd9, MEM_SW = 4'd10
    } mem_ctrl_e;

    typedef enum logic [3:0] {
        BRA_NONE, BRA_EQ, BRA_NE, BRA_LT, BRA_GE, BRA_LTU, BRA_GEU, BRA_JAL, BRA_JALR
    } bra_ctrl_e;

    typedef enum logic {RN_FILL, RN_RUN} rn_state_e;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rn_pkg::*; (
    input  xlen_t     inst,
    input  logic      valid,
    output logic [6:0] opcode,
    output fu_type_e  fu_type,
    output logic      reg_write,
    output logic      rob_write,
    output imm_sel_e  imm_sel,
    output op_sel_e   op_a_sel,
    output op_sel_e   op_b_sel,
    output alu_ctrl_e alu_ctrl,
    output mem_ctrl_e mem_ctrl,
    output bra_ctrl_e bra_ctrl
);

    logic [2:0] funct3;
    logic       funct7_b5;
    alu_ctrl_e  alu_f3;

    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];

    // arithmetic select shared by OP and OPIMM, sub is only legal on OP
    always_comb begin
        case (funct3)
            3'd0:    alu_f3 = (funct7_b5 && inst[6:0] == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'd1:    alu_f3 = ALU_SLL;
            3'd2:    alu_f3 = ALU_SLT;
            3'd3:    alu_f3 = ALU_SLTU;
            3'd4:    alu_f3 = ALU_XOR;
            3'd5:    alu_f3 = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'd6:    alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        opcode    = '0;
        fu_type   = FU_NONE;
        reg_write = 1'b0;
        rob_write = 1'b0;
        imm_sel   = IMM_NONE;
        op_a_sel  = OPSEL_REG;
        op_b_sel  = OPSEL_REG;
        alu_ctrl  = ALU_ADD;
        mem_ctrl  = MEM_NONE;
        bra_ctrl  = BRA_NONE;
        if (valid) begin
            case (inst[6:0])
                OPC_OP, OPC_OPIMM: begin
                    fu_type   = FU_ALU;
                    reg_write = 1'b1;
                    alu_ctrl  = alu_f3;
                    if (inst[6:0] == OPC_OPIMM) begin
                        imm_sel  = IMM_I;
                        op_b_sel = OPSEL_IMM;
                    end
                end
                OPC_LUI, OPC_AUIPC: begin
                    fu_type   = FU_ALU;
                    reg_write = 1'b1;
                    imm_sel   = IMM_U;
                    op_a_sel  = (inst[6:0] == OPC_LUI) ? OPSEL_ZERO : OPSEL_PC;
                    op_b_sel  = OPSEL_IMM;
                end
                OPC_LOAD: begin
                    fu_type   = FU_MEM;
                    reg_write = 1'b1;
                    imm_sel   = IMM_I;
                    case (funct3)
                        3'd0:    mem_ctrl = MEM_LB;
                        3'd1:    mem_ctrl = MEM_LH;
                        3'd2:    mem_ctrl = MEM_LW;
                        3'd4:    mem_ctrl = MEM_LBU;
                        3'd5:    mem_ctrl = MEM_LHU;
                        default: mem_ctrl = MEM_NONE;
                    endcase
                end
                OPC_STORE: begin
                    fu_type = FU_MEM;
                    imm_sel = IMM_S;
                    case (funct3)
                        3'd0:    mem_ctrl = MEM_SB;
                        3'd1:    mem_ctrl = MEM_SH;
                        3'd2:    mem_ctrl = MEM_SW;
                        default: mem_ctrl = MEM_NONE;
                    endcase
                end
                OPC_BRANCH: begin
                    fu_type = FU_BRA;
                    imm_sel = IMM_B;
                    case (funct3)
                        3'd0:    bra_ctrl = BRA_EQ;
                        3'd1:    bra_ctrl = BRA_NE;
                        3'd4:    bra_ctrl = BRA_LT;
                        3'd5:    bra_ctrl = BRA_GE;
                        3'd6:    bra_ctrl = BRA_LTU;
                        3'd7:    bra_ctrl = BRA_GEU;
                        default: bra_ctrl = BRA_NONE;
                    endcase
                end
                OPC_JAL, OPC_JALR: begin
                    fu_type   = FU_BRA;
                    reg_write = 1'b1;
                    imm_sel   = (inst[6:0] == OPC_JAL) ? IMM_J : IMM_I;
                    bra_ctrl  = (inst[6:0] == OPC_JAL) ? BRA_JAL : BRA_JALR;
                end
                default: ;
            endcase
            // anything that reached a class above is a real instruction
            if (fu_type != FU_NONE) begin
                opcode    = inst[6:0];
                rob_write = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/id_rn_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_rn_reg import rn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       en,
    input  logic       flush,
    input  logic       stall,
    input  xlen_t      pc_id,
    input  xlen_t      inst_id,
    input  logic [6:0] opcode_id,
    input  fu_type_e   fu_type_id,
    input  logic       reg_write_id,
    input  logic       rob_write_id,
    input  imm_sel_e   imm_sel_id,
    input  op_sel_e    op_a_sel_id,
    input  op_sel_e    op_b_sel_id,
    input  alu_ctrl_e  alu_ctrl_id,
    input  mem_ctrl_e  mem_ctrl_id,
    input  bra_ctrl_e  bra_ctrl_id,
    output xlen_t      pc_rn,
    output xlen_t      inst_rn,
    output logic [6:0] opcode_rn,
    output fu_type_e   fu_type_rn,
    output logic       reg_write_rn,
    output logic       rob_write_rn,
    output imm_sel_e   imm_sel_rn,
    output op_sel_e    op_a_sel_rn,
    output op_sel_e    op_b_sel_rn,
    output alu_ctrl_e  alu_ctrl_rn,
    output mem_ctrl_e  mem_ctrl_rn,
    output bra_ctrl_e  bra_ctrl_rn
);

    // stall holds, flush leaves a bubble with the pc kept, otherwise load
    always_ff @(posedge clk) begin
        if (rst || (en && !stall && flush)) begin
            if (rst) begin
                pc_rn <= '0;
            end
            inst_rn      <= '0;
            opcode_rn    <= '0;
            fu_type_rn   <= FU_NONE;
            reg_write_rn <= 1'b0;
            rob_write_rn <= 1'b0;
            imm_sel_rn   <= IMM_NONE;
            op_a_sel_rn  <= OPSEL_REG;
            op_b_sel_rn  <= OPSEL_REG;
            alu_ctrl_rn  <= ALU_ADD;
            mem_ctrl_rn  <= MEM_NONE;
            bra_ctrl_rn  <= BRA_NONE;
        end else if (en && !stall) begin
            pc_rn        <= pc_id;
            inst_rn      <= inst_id;
            opcode_rn    <= opcode_id;
            fu_type_rn   <= fu_type_id;
            reg_write_rn <= reg_write_id;
            rob_write_rn <= rob_write_id;
            imm_sel_rn   <= imm_sel_id;
            op_a_sel_rn  <= op_a_sel_id;
            op_b_sel_rn  <= op_b_sel_id;
            alu_ctrl_rn  <= alu_ctrl_id;
            mem_ctrl_rn  <= mem_ctrl_id;
            bra_ctrl_rn  <= bra_ctrl_id;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map import rn_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    output preg_t prs1,
    output preg_t prs2,
    output preg_t old_prd,
    input  logic  wr_en,
    input  preg_t wr_preg
);

    preg_t map_q [NUM_ARCH];

    // out of reset every architectural register owns the physical tag of the same number
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (wr_en && rd != '0) begin
            map_q[rd] <= wr_preg;
        end
    end

    // x0 stays on tag 0 for good
    assign prs1    = map_q[rs1];
    assign prs2    = map_q[rs2];
    assign old_prd = map_q[rd];

endmodule

`default_nettype wire

// File: logic/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import rn_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  preg_t   push_preg,
    input  logic    pop,
    output preg_t   head_preg,
    output fl_cnt_t count
);

    preg_t                       slots [NUM_FREE];
    logic [$clog2(NUM_FREE)-1:0] wr_ptr;
    logic [$clog2(NUM_FREE)-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_preg;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // only meaningful while count is nonzero
    assign head_preg = slots[rd_ptr];

endmodule

`default_nettype wire

// File: logic/rename_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl import rn_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    need_preg,
    input  fl_cnt_t count,
    input  logic    free_valid,
    input  preg_t   free_preg,
    output logic    ready,
    output logic    stall,
    output logic    fl_push,
    output preg_t   fl_push_preg
);

    rn_state_e                   state;
    logic [$clog2(NUM_FREE)-1:0] fill_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RN_FILL;
            fill_cnt <= '0;
        end else if (state == RN_FILL) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == NUM_FREE - 1) begin
                state <= RN_RUN;
            end
        end
    end

    assign ready = (state == RN_RUN);

    // the fill hands out the upper half of the physical file, the lower half is mapped
    always_comb begin
        if (state == RN_FILL) begin
            fl_push      = 1'b1;
            fl_push_preg = preg_t'(NUM_PHYS - NUM_FREE) + preg_t'(fill_cnt);
        end else begin
            fl_push      = free_valid;
            fl_push_preg = free_preg;
        end
    end

    assign stall = ready && need_preg && count == '0;

endmodule

`default_nettype wire

// File: logic/rename_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module rename_frontend import rn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  xlen_t      in_pc,
    input  xlen_t      in_inst,
    input  logic       flush,
    input  logic       free_valid,
    input  preg_t      free_preg,
    output logic       ready,
    output logic       stall,
    output logic       rn_valid,
    output xlen_t      rn_pc,
    output logic [6:0] rn_opcode,
    output fu_type_e   rn_fu_type,
    output logic       rn_reg_write,
    output imm_sel_e   rn_imm_sel,
    output op_sel_e    rn_op_a_sel,
    output op_sel_e    rn_op_b_sel,
    output alu_ctrl_e  rn_alu_ctrl,
    output mem_ctrl_e  rn_mem_ctrl,
    output bra_ctrl_e  rn_bra_ctrl,
    output preg_t      rn_prs1,
    output preg_t      rn_prs2,
    output preg_t      rn_prd,
    output preg_t      rn_old_prd
);

    logic [6:0] opcode_id;
    fu_type_e   fu_type_id;
    logic       reg_write_id;
    logic       rob_write_dec;
    imm_sel_e   imm_sel_id;
    op_sel_e    op_a_sel_id, op_b_sel_id;
    alu_ctrl_e  alu_ctrl_id;
    mem_ctrl_e  mem_ctrl_id;
    bra_ctrl_e  bra_ctrl_id;
    xlen_t      inst_rn;
    logic       rob_write_rn;
    logic       need_preg, fire, fl_push;
    preg_t      fl_push_preg, head_preg;
    fl_cnt_t    fl_count;

    inst_decoder inst_decoder_i (
        .inst(in_inst), .valid(in_valid), .opcode(opcode_id), .fu_type(fu_type_id),
        .reg_write(reg_write_id), .rob_write(rob_write_dec), .imm_sel(imm_sel_id),
        .op_a_sel(op_a_sel_id), .op_b_sel(op_b_sel_id), .alu_ctrl(alu_ctrl_id),
        .mem_ctrl(mem_ctrl_id), .bra_ctrl(bra_ctrl_id)
    );

    id_rn_reg id_rn_reg_i (
        .clk(clk), .rst(rst), .en(ready), .flush(flush), .stall(stall),
        .pc_id(in_pc), .inst_id(in_inst), .opcode_id(opcode_id), .fu_type_id(fu_type_id),
        .reg_write_id(reg_write_id), .rob_write_id(rob_write_dec & in_valid),
        .imm_sel_id(imm_sel_id), .op_a_sel_id(op_a_sel_id), .op_b_sel_id(op_b_sel_id),
        .alu_ctrl_id(alu_ctrl_id), .mem_ctrl_id(mem_ctrl_id), .bra_ctrl_id(bra_ctrl_id),
        .pc_rn(rn_pc), .inst_rn(inst_rn), .opcode_rn(rn_opcode), .fu_type_rn(rn_fu_type),
        .reg_write_rn(rn_reg_write), .rob_write_rn(rob_write_rn), .imm_sel_rn(rn_imm_sel),
        .op_a_sel_rn(rn_op_a_sel), .op_b_sel_rn(rn_op_b_sel), .alu_ctrl_rn(rn_alu_ctrl),
        .mem_ctrl_rn(rn_mem_ctrl), .bra_ctrl_rn(rn_bra_ctrl)
    );

    // rd lives in bits 11:7 whatever the format, stores and branches never set reg_write
    assign need_preg = rob_write_rn & rn_reg_write & (inst_rn[11:7] != '0);
    assign fire      = need_preg & ~stall;
    assign rn_valid  = rob_write_rn & ~stall;
    assign rn_prd    = head_preg & {$bits(preg_t){fire}};

    rename_map rename_map_i (
        .clk(clk), .rst(rst), .rs1(inst_rn[19:15]), .rs2(inst_rn[24:20]),
        .rd(inst_rn[11:7]), .prs1(rn_prs1), .prs2(rn_prs2), .old_prd(rn_old_prd),
        .wr_en(fire), .wr_preg(head_preg)
    );

    free_list free_list_i (
        .clk(clk), .rst(rst), .push(fl_push), .push_preg(fl_push_preg), .pop(fire),
        .head_preg(head_preg), .count(fl_count)
    );

    rename_ctrl rename_ctrl_i (
        .clk(clk), .rst(rst), .need_preg(need_preg), .count(fl_count),
        .free_valid(free_valid), .free_preg(free_preg), .ready(ready), .stall(stall),
        .fl_push(fl_push), .fl_push_preg(fl_push_preg)
    );

endmodule

`default_nettype wire

// File: dv/rename_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_frontend_tb import rn_pkg::*; ();

    logic       clk, rst, in_valid, flush, free_valid;
    xlen_t      in_pc, in_inst;
    preg_t      free_preg;
    logic       ready, stall, rn_valid, rn_reg_write;
    xlen_t      rn_pc;
    logic [6:0] rn_opcode;
    fu_type_e   rn_fu_type;
    imm_sel_e   rn_imm_sel;
    op_sel_e    rn_op_a_sel, rn_op_b_sel;
    alu_ctrl_e  rn_alu_ctrl;
    mem_ctrl_e  rn_mem_ctrl;
    bra_ctrl_e  rn_bra_ctrl;
    preg_t      rn_prs1, rn_prs2, rn_prd, rn_old_prd;

    // reference rename state, updated whenever the model expects a rename to fire
    preg_t      ref_map [NUM_ARCH];
    preg_t      free_q [$];
    xlen_t      cur_pc = 32'h100;
    int         errors = 0;
    int         checks = 0;
    int         test_errors = 0;
    int         seed = 32'hd32c;

    rename_frontend rename_frontend_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // stop a hung run after 2000 clock cycles
    initial begin
        #(2000 * 4);
        $display("timeout: the tests did not finish within 2000 clock cycles");
        $display("Test failures found");
        $finish;
    end

    function automatic xlen_t encode(input logic [6:0] f7, input areg_t rs2, input areg_t rs1,
                                     input logic [2:0] f3, input areg_t rd,
                                     input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic writes_rd(input logic [6:0] opc);
        case (opc)
            OPC_OP, OPC_OPIMM, OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_JAL, OPC_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_known(input logic [6:0] opc);
        return writes_rd(opc) || opc == OPC_STORE || opc == OPC_BRANCH;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            test_errors++;
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic check_rename(input xlen_t pc, input xlen_t inst);
        areg_t rd;
        logic  valid;
        logic  need;
        logic  empty;
        rd    = inst[11:7];
        valid = is_known(inst[6:0]);
        need  = valid && writes_rd(inst[6:0]) && rd != 5'd0;
        empty = free_q.size() == 0;
        check_val("stall", stall, need && empty);
        check_val("rn_valid", rn_valid, valid && !(need && empty));
        check_val("rn_pc", rn_pc, pc);
        check_val("rn_prd", rn_prd, (need && !empty) ? free_q[0] : 0);
        if (valid) begin
            check_val("rn_prs1", rn_prs1, ref_map[inst[19:15]]);
            check_val("rn_prs2", rn_prs2, ref_map[inst[24:20]]);
            check_val("rn_old_prd", rn_old_prd, ref_map[rd]);
        end
        // the pop and the map write land on the next edge
        if (need && !empty) begin
            ref_map[rd] = free_q.pop_front();
        end
    endtask

    task automatic issue(input xlen_t inst);
        cur_pc   = cur_pc + 4;
        in_valid = 1'b1;
        in_pc    = cur_pc;
        in_inst  = inst;
        @(posedge clk);
        @(negedge clk);
        check_rename(cur_pc, inst);
    endtask

    task automatic idle();
        in_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic decode_case(input xlen_t inst, input fu_type_e fu, input logic rw,
                               input imm_sel_e imm, input op_sel_e opa, input op_sel_e opb,
                               input alu_ctrl_e alu, input mem_ctrl_e mem, input bra_ctrl_e bra);
        issue(inst);
        check_val("rn_opcode", rn_opcode, is_known(inst[6:0]) ? inst[6:0] : 7'd0);
        check_val("rn_fu_type", rn_fu_type, fu);
        check_val("rn_reg_write", rn_reg_write, rw);
        check_val("rn_imm_sel", rn_imm_sel, imm);
        check_val("rn_op_a_sel", rn_op_a_sel, opa);
        check_val("rn_op_b_sel", rn_op_b_sel, opb);
        check_val("rn_alu_ctrl", rn_alu_ctrl, alu);
        check_val("rn_mem_ctrl", rn_mem_ctrl, mem);
        check_val("rn_bra_ctrl", rn_bra_ctrl, bra);
    endtask

    task automatic test_reset_fill();
        // returns offered during the fill must not reach the free list
        free_valid = 1'b1;
        free_preg  = 6'd5;
        for (int i = 0; i < NUM_FREE; i++) begin
            check_val("ready", ready, 0);
            check_val("stall", stall, 0);
            check_val("rn_valid", rn_valid, 0);
            @(posedge clk);
            @(negedge clk);
        end
        free_valid = 1'b0;
        check_val("ready", ready, 1);
        check_val("rn_fu_type", rn_fu_type, FU_NONE);
        check_val("rn_reg_write", rn_reg_write, 0);
        check_val("rn_prd", rn_prd, 0);
        report_test("reset and fill");
    endtask

    task automatic test_decode();
        decode_case(encode(7'h00, 5'd7, 5'd6, 3'd0, 5'd5, OPC_OP), FU_ALU, 1'b1, IMM_NONE,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h20, 5'd7, 5'd6, 3'd0, 5'd5, OPC_OP), FU_ALU, 1'b1, IMM_NONE,
                    OPSEL_REG, OPSEL_REG, ALU_SUB, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h20, 5'd7, 5'd6, 3'd5, 5'd5, OPC_OP), FU_ALU, 1'b1, IMM_NONE,
                    OPSEL_REG, OPSEL_REG, ALU_SRA, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h20, 5'd7, 5'd6, 3'd5, 5'd5, OPC_OPIMM), FU_ALU, 1'b1, IMM_I,
                    OPSEL_REG, OPSEL_IMM, ALU_SRA, MEM_NONE, BRA_NONE);
        // bit 30 is only immediate data for addi
        decode_case(encode(7'h20, 5'd7, 5'd6, 3'd0, 5'd5, OPC_OPIMM), FU_ALU, 1'b1, IMM_I,
                    OPSEL_REG, OPSEL_IMM, ALU_ADD, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h12, 5'd3, 5'd4, 3'd1, 5'd5, OPC_LUI), FU_ALU, 1'b1, IMM_U,
                    OPSEL_ZERO, OPSEL_IMM, ALU_ADD, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h12, 5'd3, 5'd4, 3'd1, 5'd6, OPC_AUIPC), FU_ALU, 1'b1, IMM_U,
                    OPSEL_PC, OPSEL_IMM, ALU_ADD, MEM_NONE, BRA_NONE);
        decode_case(encode(7'h00, 5'd8, 5'd6, 3'd2, 5'd7, OPC_LOAD), FU_MEM, 1'b1, IMM_I,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_LW, BRA_NONE);
        decode_case(encode(7'h00, 5'd7, 5'd6, 3'd2, 5'd4, OPC_STORE), FU_MEM, 1'b0, IMM_S,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_SW, BRA_NONE);
        decode_case(encode(7'h00, 5'd7, 5'd6, 3'd1, 5'd8, OPC_BRANCH), FU_BRA, 1'b0, IMM_B,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_NONE, BRA_NE);
        decode_case(encode(7'h01, 5'd2, 5'd0, 3'd0, 5'd1, OPC_JAL), FU_BRA, 1'b1, IMM_J,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_NONE, BRA_JAL);
        decode_case(encode(7'h00, 5'd4, 5'd1, 3'd0, 5'd1, OPC_JALR), FU_BRA, 1'b1, IMM_I,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_NONE, BRA_JALR);
        decode_case(encode(7'h00, 5'd7, 5'd6, 3'd0, 5'd5, 7'b1111111), FU_NONE, 1'b0, IMM_NONE,
                    OPSEL_REG, OPSEL_REG, ALU_ADD, MEM_NONE, BRA_NONE);
        idle();
        report_test("decode");
    endtask

    task automatic test_alloc();
        areg_t rd;
        areg_t prev;
        preg_t first;
        prev  = 5'd1;
        first = free_q[0];
        for (int i = 0; i < 6; i++) begin
            rd = 5'd1 + areg_t'({$random(seed)} % 31);
            // each writer reads the previous destination and sees its fresh tag
            issue(encode(7'h00, prev, rd, 3'd0, rd, OPC_OP));
            check_val("rn_prd", rn_prd, first + i);
            prev = rd;
        end
        issue(encode(7'h00, prev, prev, 3'd4, 5'd0, OPC_OP));
        idle();
        report_test("rename allocation");
    endtask

    task automatic test_x0_store();
        issue(encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd0, OPC_OPIMM));
        issue(encode(7'h00, 5'd3, 5'd2, 3'd2, 5'd9, OPC_STORE));
        issue(encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd9, OPC_BRANCH));
        issue(encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd11, OPC_OP));
        idle();
        report_test("x0 and stores");
    endtask

    task automatic test_flush();
        issue(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd8, OPC_OP));
        flush   = 1'b1;
        in_pc   = cur_pc + 4;
        in_inst = encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd9, OPC_OP);
        @(posedge clk);
        @(negedge clk);
        flush    = 1'b0;
        in_valid = 1'b0;
        check_val("rn_valid", rn_valid, 0);
        check_val("rn_pc", rn_pc, cur_pc);
        check_val("rn_prd", rn_prd, 0);
        issue(encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd10, OPC_OP));
        idle();
        report_test("flush");
    endtask

    task automatic test_exhaust();
        xlen_t held;
        while (free_q.size() != 0) begin
            issue(encode(7'h00, 5'd4, 5'd3, 3'd0, 5'd1 + areg_t'({$random(seed)} % 31), OPC_OP));
        end
        held = encode(7'h00, 5'd4, 5'd3, 3'd0, 5'd12, OPC_OP);
        issue(held);
        // a stalled register must ignore whatever now sits at its input
        in_valid = 1'b0;
        in_pc    = cur_pc + 4;
        @(posedge clk);
        @(negedge clk);
        check_val("stall", stall, 1);
        check_val("rn_valid", rn_valid, 0);
        check_val("rn_pc", rn_pc, cur_pc);
        check_val("rn_opcode", rn_opcode, OPC_OP);
        free_valid = 1'b1;
        free_preg  = 6'd13;
        @(posedge clk);
        @(negedge clk);
        free_valid = 1'b0;
        free_q.push_back(6'd13);
        check_rename(cur_pc, held);
        idle();
        report_test("exhaustion");
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        flush      = 1'b0;
        free_valid = 1'b0;
        free_preg  = '0;
        for (int i = 0; i < NUM_ARCH; i++) begin
            ref_map[i] = preg_t'(i);
        end
        for (int i = 0; i < NUM_FREE; i++) begin
            free_q.push_back(preg_t'(NUM_PHYS - NUM_FREE + i));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_fill();
        test_decode();
        test_alloc();
        test_x0_store();
        test_flush();
        test_exhaust();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_frontend.f
logic/rn_pkg.sv
logic/inst_decoder.sv
logic/id_rn_reg.sv
logic/rename_map.sv
logic/free_list.sv
logic/rename_ctrl.sv
logic/rename_frontend.sv
dv/rename_frontend_tb.sv
